// File: common/router_config.svh
`ifndef ROUTER_CONFIG_SVH
`define ROUTER_CONFIG_SVH

// ****************************************
// router channel sizing
// ****************************************

// input ports feeding one output channel, ordered L, N, E, W, S.
`define ROUTER_PORTS 5

// packet length field carried by a header flit.
`define LEN_WIDTH 12

// flit payload width.
`define PAYLOAD_WIDTH 16

// arbiter state after reset is the one-hot idle code.
`define ARB_RESET_STATE 6'b000001

`endif

// File: common/router_pkg.sv
`include "router_config.svh"

package router_pkg;

  // flit kinds.
  // only a header loads the grant timer.
  typedef enum logic [2:0] {
    body   = 3'b000,
    header = 3'b001,
    tail   = 3'b010
  } flitKind_e;

  // one-hot arbiter states, one per input plus idle.
  typedef enum logic [5:0] {
    idle   = 6'b000001,
    grantL = 6'b000010,
    grantN = 6'b000100,
    grantE = 6'b001000,
    grantW = 6'b010000,
    grantS = 6'b100000
  } arbState_e;

  typedef struct packed {
    flitKind_e                 kind;
    logic [`LEN_WIDTH-1:0]     length;
    logic [`PAYLOAD_WIDTH-1:0] payload;
  } flit_t;

  typedef struct packed {
    logic  req;
    flit_t flit;
  } portIn_t;

  // input indices into the port array.
  localparam int portL = 0;
  localparam int portN = 1;
  localparam int portE = 2;
  localparam int portW = 3;
  localparam int portS = 4;

endpackage

// File: arbiter/grantTimer.sv
`timescale 1ns/10ps
`include "router_config.svh"

module grantTimer (
  input  logic                  clk,
  input  logic                  rst,
  input  router_pkg::flitKind_e kind,
  input  logic [`LEN_WIDTH-1:0] length,
  input  logic                  runTimer,
  output logic                  timesUp
);
  import router_pkg::*;

  logic [`LEN_WIDTH-1:0] limit;
  logic [`LEN_WIDTH-1:0] count;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      limit <= '0;
      count <= '0;
    end
    else
    begin
      // every header seen on this input sets a new limit.
      if (kind == header)
      begin
        limit <= length;
      end
      if (runTimer)
      begin
        count <= count + 1'b1;
      end
      else
      begin
        count <= '0;
      end
    end
  end

  // a limit of n lets the holder keep the channel for n+1 cycles.
  assign timesUp = (count == limit);

endmodule

// File: arbiter/outputArbiter.sv
`timescale 1ns/10ps
`include "router_config.svh"

module outputArbiter (
  input  logic                                    clk,
  input  logic                                    rst,
  input  router_pkg::portIn_t [`ROUTER_PORTS-1:0] inPorts,
  output router_pkg::arbState_e                   grant
);
  import router_pkg::*;

  arbState_e                state;
  arbState_e                nextState;
  logic [`ROUTER_PORTS-1:0] reqs;
  logic [`ROUTER_PORTS-1:0] runTimer;
  logic [`ROUTER_PORTS-1:0] timesUp;

  // one-hot grant code of an input index.
  function automatic arbState_e portGrant(input int idx);
    return arbState_e'(6'b000010 << idx);
  endfunction

  // first requester among span ports, starting at start and wrapping after S.
  // scanned from the far end so the earliest port wins.
  function automatic arbState_e scan(
    input logic [`ROUTER_PORTS-1:0] r,
    input int                       start,
    input int                       span
  );
    arbState_e pick;
    int        k;
    int        idx;
    pick = idle;
    for (k = `ROUTER_PORTS - 1; k >= 0; k--)
    begin
      idx = start + k;
      if (idx >= `ROUTER_PORTS)
      begin
        idx = idx - `ROUTER_PORTS;
      end
      if ((k < span) && r[idx])
      begin
        pick = portGrant(idx);
      end
    end
    return pick;
  endfunction

  // ****************************************
  // per-input grant timers
  // ****************************************

  for (genvar p = 0; p < `ROUTER_PORTS; p++)
  begin : gTimer
    assign reqs[p] = inPorts[p].req;

    grantTimer timer_i (
      .clk      (clk),
      .rst      (rst),
      .kind     (inPorts[p].flit.kind),
      .length   (inPorts[p].flit.length),
      .runTimer (runTimer[p]),
      .timesUp  (timesUp[p])
    );
  end

  // ****************************************
  // grant state machine
  // ****************************************

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= arbState_e'(`ARB_RESET_STATE);
    end
    else
    begin
      state <= nextState;
    end
  end

  assign grant = state;

  // a holder keeps the channel while it requests and its time is not up.
  // on release the scan covers the other four ports only, so a lone
  // requester comes back through idle.
  always_comb
  begin
    runTimer  = '0;
    nextState = idle;
    case (state)
      idle:
      begin
        nextState = scan(reqs, portL, `ROUTER_PORTS);
      end
      grantL:
      begin
        if (reqs[portL] && !timesUp[portL])
        begin
          runTimer[portL] = 1'b1;
          nextState       = grantL;
        end
        else
        begin
          nextState = scan(reqs, portN, `ROUTER_PORTS - 1);
        end
      end
      grantN:
      begin
        if (reqs[portN] && !timesUp[portN])
        begin
          runTimer[portN] = 1'b1;
          nextState       = grantN;
        end
        else
        begin
          nextState = scan(reqs, portE, `ROUTER_PORTS - 1);
        end
      end
      grantE:
      begin
        if (reqs[portE] && !timesUp[portE])
        begin
          runTimer[portE] = 1'b1;
          nextState       = grantE;
        end
        else
        begin
          nextState = scan(reqs, portW, `ROUTER_PORTS - 1);
        end
      end
      grantW:
      begin
        // west hands over to south first, like every other port.
        if (reqs[portW] && !timesUp[portW])
        begin
          runTimer[portW] = 1'b1;
          nextState       = grantW;
        end
        else
        begin
          nextState = scan(reqs, portS, `ROUTER_PORTS - 1);
        end
      end
      grantS:
      begin
        if (reqs[portS] && !timesUp[portS])
        begin
          runTimer[portS] = 1'b1;
          nextState       = grantS;
        end
        else
        begin
          nextState = scan(reqs, portL, `ROUTER_PORTS - 1);
        end
      end
      default:
      begin
        nextState = idle;
      end
    endcase
  end

endmodule

// File: design/outputStage.sv
`timescale 1ns/10ps
`include "router_config.svh"

module outputStage (
  input  logic                                    clk,
  input  logic                                    rst,
  input  router_pkg::portIn_t [`ROUTER_PORTS-1:0] inPorts,
  input  router_pkg::arbState_e                   grant,
  output router_pkg::flit_t                       outFlit,
  output logic                                    outValid
);
  import router_pkg::*;

  portIn_t selPort;

  // input named by the one-hot grant.
  // idle selects nothing, so req reads low.
  always_comb
  begin
    case (grant)
      grantL:  selPort = inPorts[portL];
      grantN:  selPort = inPorts[portN];
      grantE:  selPort = inPorts[portE];
      grantW:  selPort = inPorts[portW];
      grantS:  selPort = inPorts[portS];
      default: selPort = '0;
    endcase
  end

  // ****************************************
  // output link register
  // ****************************************

  always_ff @(posedge clk)
  begin
    outFlit <= selPort.flit;
  end

  // valid follows the granted input's request, one cycle behind grant.
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      outValid <= 1'b0;
    end
    else
    begin
      outValid <= selPort.req;
    end
  end

endmodule

// File: design/outputPort.sv
`timescale 1ns/10ps
`include "router_config.svh"

module outputPort (
  input  logic                                    clk,
  input  logic                                    rst,
  input  router_pkg::portIn_t [`ROUTER_PORTS-1:0] inPorts,
  output router_pkg::flit_t                       outFlit,
  output logic                                    outValid,
  output router_pkg::arbState_e                   grant
);
  import router_pkg::*;

  // ****************************************
  // arbitration
  // ****************************************

  // grant is registered here and also leaves the port for observation.
  outputArbiter arbiter_i (
    .clk     (clk),
    .rst     (rst),
    .inPorts (inPorts),
    .grant   (grant)
  );

  // ****************************************
  // output link
  // ****************************************

  // flit of the granted input, registered one cycle after the grant.
  outputStage stage_i (
    .clk      (clk),
    .rst      (rst),
    .inPorts  (inPorts),
    .grant    (grant),
    .outFlit  (outFlit),
    .outValid (outValid)
  );

endmodule

// File: testbench/clockGen.sv
`timescale 1ns/10ps

module clockGen (
  output logic clk,
  output logic rst
);

  // 100 ns period.
  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // reset covers the first four rising edges.
  initial
  begin
    rst = 1'b1;
    repeat (4) @(posedge clk);
    #1 rst = 1'b0;
  end

endmodule

// File: testbench/outputPortAsserts.sv
`timescale 1ns/10ps

module outputPortAsserts (
  input logic                  clk,
  input logic                  rst,
  input router_pkg::arbState_e grant,
  input logic                  outValid
);
  import router_pkg::*;

  // ****************************************
  // arbitration protocol
  // ****************************************

  property grantLegal;
    @(posedge clk) disable iff (rst)
      grant inside {idle, grantL, grantN, grantE, grantW, grantS};
  endproperty

  property resetState;
    @(posedge clk) rst |=> (grant == idle) && !outValid;
  endproperty

  // a flit only leaves when some input held the grant the cycle before.
  property validNeedsGrant;
    @(posedge clk) disable iff (rst)
      ($past(grant) == idle) |-> !outValid;
  endproperty

  grantLegalA: assert property (grantLegal)
    else $error("grant is not one of the six one-hot states");

  resetStateA: assert property (resetState)
    else $error("grant or outValid not cleared after reset");

  validNeedsGrantA: assert property (validNeedsGrant)
    else $error("outValid high although the previous grant was idle");

endmodule

bind outputPort outputPortAsserts asserts_i (
  .clk      (clk),
  .rst      (rst),
  .grant    (grant),
  .outValid (outValid)
);

// File: testbench/routerTb.sv
`timescale 1ns/10ps
`include "router_config.svh"

module routerTb;
  import router_pkg::*;

  localparam int lenMod = 1 << `LEN_WIDTH;

  logic                        clk;
  logic                        rst;
  portIn_t [`ROUTER_PORTS-1:0] inPorts;
  flit_t                       outFlit;
  logic                        outValid;
  arbState_e                   grant;

  // reference model state where -1 stands for idle.
  int    expPort;
  int    limits [`ROUTER_PORTS];
  int    counts [`ROUTER_PORTS];
  flit_t expFlit;
  logic  expValid;
  logic  expHasFlit;
  string testName;

  clockGen clk_i (
    .clk (clk),
    .rst (rst)
  );

  outputPort dut_i (
    .clk      (clk),
    .rst      (rst),
    .inPorts  (inPorts),
    .outFlit  (outFlit),
    .outValid (outValid),
    .grant    (grant)
  );

  task automatic failValue(input string check, input logic [63:0] expV, input logic [63:0] actV);
    $display("Error in %s, %s: expected %0h, actual %0h", testName, check, expV, actV);
    $display("*** FAILED ***");
    $fatal(1);
  endtask

  task automatic failTimeout(input string what);
    $display("Timeout in %s: %s did not happen in time", testName, what);
    $display("*** FAILED ***");
    $fatal(1);
  endtask

  function automatic arbState_e stateCode(input int p);
    case (p)
      0:       return grantL;
      1:       return grantN;
      2:       return grantE;
      3:       return grantW;
      4:       return grantS;
      default: return idle;
    endcase
  endfunction

  // first requester of span ports from start in the order L, N, E, W, S.
  function automatic int firstReq(input int start, input int span);
    int k;
    for (k = 0; k < span; k++)
      if (inPorts[(start + k) % `ROUTER_PORTS].req)
        return (start + k) % `ROUTER_PORTS;
    return -1;
  endfunction

  // ****************************************
  // reference model and checks
  // ****************************************

  task automatic modelStep();
    int  nextPort;
    int  k;
    if (rst)
    begin
      expPort    = -1;
      expValid   = 1'b0;
      expHasFlit = 1'b0;
      for (k = 0; k < `ROUTER_PORTS; k++)
      begin
        limits[k] = 0;
        counts[k] = 0;
      end
    end
    else
    begin
      if (expPort < 0)
        nextPort = firstReq(0, `ROUTER_PORTS);
      else if (inPorts[expPort].req && (counts[expPort] != limits[expPort]))
        nextPort = expPort;
      else
        nextPort = firstReq((expPort + 1) % `ROUTER_PORTS, `ROUTER_PORTS - 1);
      expValid   = (expPort >= 0) ? inPorts[expPort].req : 1'b0;
      expHasFlit = (expPort >= 0);
      if (expHasFlit)
        expFlit = inPorts[expPort].flit;
      for (k = 0; k < `ROUTER_PORTS; k++)
      begin
        if (inPorts[k].flit.kind == header)
          limits[k] = inPorts[k].flit.length;
        counts[k] = ((k == expPort) && (nextPort == expPort)) ? (counts[k] + 1) % lenMod : 0;
      end
      expPort = nextPort;
    end
  endtask

  task automatic checkDut();
    arbState_e expGrant;
    expGrant = stateCode(expPort);
    assert (grant === expGrant)
      else failValue("grant", expGrant, grant);
    assert (outValid === expValid)
      else failValue("outValid", expValid, outValid);
    assert (!expHasFlit || (outFlit === expFlit))
      else failValue("outFlit", expFlit, outFlit);
  endtask

  // model and DUT see the same inputs and outputs are read once settled.
  task automatic tick();
    @(posedge clk);
    modelStep();
    #10;
    checkDut();
  endtask

  task automatic drivePort(input int p, input logic r, input flitKind_e kind,
                           input logic [`LEN_WIDTH-1:0] len);
    inPorts[p].req          = r;
    inPorts[p].flit.kind    = kind;
    inPorts[p].flit.length  = len;
    inPorts[p].flit.payload = $urandom;
  endtask

  task automatic clearInputs();
    int k;
    for (k = 0; k < `ROUTER_PORTS; k++)
      drivePort(k, 1'b0, body, 0);
  endtask

  task automatic waitIdle();
    int waits;
    waits = 0;
    while (expPort >= 0)
    begin
      tick();
      waits++;
      if (waits > 20)
        failTimeout("return of the grant to idle");
    end
  endtask

  task automatic measureHold(input int p, output int held);
    held = 0;
    while (grant === stateCode(p))
    begin
      held++;
      tick();
      if (held > 100)
        failTimeout("release of the grant");
    end
  endtask

  // ****************************************
  // stimulus
  // ****************************************

  initial
  begin
    int n;
    int held;
    int waits;
    int lastPort;
    int handovers;
    int westSouth;
    int k;
    void'($urandom(19565));
    testName   = "reset";
    expPort    = -1;
    expValid   = 1'b0;
    expHasFlit = 1'b0;
    clearInputs();
    waits = 0;
    do
    begin
      tick();
      waits++;
      if (waits > 10)
        failTimeout("release of reset");
    end
    while (rst);
    repeat (3) tick();

    testName = "priority";
    for (n = 1; n < 32; n++)
    begin
      for (k = 0; k < `ROUTER_PORTS; k++)
        drivePort(k, n[k], body, 0);
      tick();
      clearInputs();
      waitIdle();
    end

    testName = "hold";
    for (n = 2; n <= 5; n += 3)
    begin
      drivePort(portE, 1'b1, header, n);
      tick();
      drivePort(portE, 1'b1, body, n);
      measureHold(portE, held);
      assert (held == n + 1)
        else failValue("hold cycles", n + 1, held);
      // a lone requester comes back through idle.
      tick();
      assert (grant === grantE)
        else failValue("regrant", grantE, grant);
      clearInputs();
      waitIdle();
    end
    drivePort(portE, 1'b1, header, 3);
    drivePort(portW, 1'b1, body, 0);
    tick();
    drivePort(portE, 1'b1, body, 3);
    measureHold(portE, held);
    assert (held == 4)
      else failValue("hold cycles", 4, held);
    assert (grant === grantW)
      else failValue("handover", grantW, grant);
    clearInputs();
    waitIdle();

    testName  = "rotation";
    lastPort  = -1;
    handovers = 0;
    westSouth = 0;
    for (waits = 0; waits < 40; waits++)
    begin
      for (k = 0; k < `ROUTER_PORTS; k++)
        drivePort(k, 1'b1, header, 1);
      tick();
      if ((expPort >= 0) && (expPort != lastPort))
      begin
        if (lastPort >= 0)
        begin
          assert (grant === stateCode((lastPort + 1) % `ROUTER_PORTS))
            else failValue("next port", stateCode((lastPort + 1) % `ROUTER_PORTS), grant);
          handovers++;
          if (lastPort == portW)
            westSouth++;
        end
        lastPort = expPort;
      end
    end
    assert ((handovers >= 10) && (westSouth > 0))
      else failValue("west to south handovers", 1, westSouth);

    testName = "release";
    clearInputs();
    waitIdle();
    drivePort(portL, 1'b1, header, 10);
    drivePort(portN, 1'b1, body, 0);
    tick();
    drivePort(portL, 1'b1, body, 10);
    repeat (2) tick();
    drivePort(portL, 1'b0, body, 10);
    tick();
    assert (grant === grantN)
      else failValue("early release", grantN, grant);
    drivePort(portN, 1'b0, body, 0);
    tick();
    assert (grant === idle)
      else failValue("release to idle", idle, grant);

    testName = "random";
    for (waits = 0; waits < 300; waits++)
    begin
      for (k = 0; k < `ROUTER_PORTS; k++)
        drivePort(k, ($urandom % 4) != 0, flitKind_e'($urandom_range(2, 0)), $urandom % 6);
      tick();
    end
    clearInputs();
    waitIdle();
    tick();
    $display("*** PASSED ***");
    $finish;
  end

endmodule

// File: build.f
+incdir+common
common/router_pkg.sv
arbiter/grantTimer.sv
arbiter/outputArbiter.sv
design/outputStage.sv
design/outputPort.sv
testbench/clockGen.sv
testbench/outputPortAsserts.sv
testbench/routerTb.sv
